/* vlog.f */
+incdir+logic
logic/amiga_timing_pkg.sv
logic/clock_enables.sv
logic/beam_counter.sv
logic/eclk_timer.sv
logic/video_sync.sv
logic/amiga_timing_top.sv
verification/amiga_timing_props.sv
verification/amiga_timing_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the amiga timing testbench with Verilator
# the verdict comes from the simulation log

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module amiga_timing_tb -Mdir obj_dir > sim.log 2>&1 &&
  ./obj_dir/Vamiga_timing_tb >> sim.log 2>&1 ||
  echo "build or run ended with an error" >> sim.log

grep -qx "TEST OK" sim.log && echo "simulation passed" && exit 0 ||
  { echo "simulation failed, see sim.log"; exit 1; }

/* verification/amiga_timing_tb.sv */
// amiga timing testbench
// checks clock phases, beam counting, sync decode and the interval timer
// timer cases come from a table applied in a loop

`include "amiga_timing_params.svh"
`default_nettype none

module amiga_timing_tb
  import amiga_timing_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int FRAME_CYC = `AT_HTOTAL * `AT_VTOTAL * 8;
  localparam int NCASE = 5;

  logic clk_28, locked;
  timer_ctrl_t timer_ctrl;
  clk_phase_t phases;
  beam_pos_t beam;
  sync_t sync;
  logic [15:0] timer_count;
  logic timer_irq;
  int cycle_cnt = 0, timeout_cycles = 0;
  int errors = 0, tests_run = 0, tests_failed = 0;
  int seed = 32'hde80_7578;
  int tc_reload[NCASE];          // reload value
  bit tc_oneshot[NCASE];
  int tc_pulses[NCASE];          // irqs expected in the watch window
  int tc_window[NCASE];          // watch window in cycles

  amiga_timing_top dut0 (.clk_28(clk_28), .locked(locked), .timer_ctrl(timer_ctrl),
    .phases(phases), .beam(beam), .sync(sync), .timer_count(timer_count),
    .timer_irq(timer_irq));

  initial begin
    clk_28 = 1'b0;
    forever #4 clk_28 = ~clk_28;
  end

  always @(posedge clk_28) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > timeout_cycles) begin
      $display("timeout: run went past %0d cycles without finishing", timeout_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic wrong_value(input string msg);
    errors++;
    $display("mismatch at %0t: %s", $time, msg);
  endtask

  task automatic missing_event(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic close_test(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) tests_failed++;
    $display("test %0d %s: %s", tests_run, name, (errors == err_before) ? "pass" : "fail");
  endtask

  // 7 MHz enables and quadrature over 400 cycles
  task automatic run_clock_phases();
    int err0, n_en, last_en, i;
    logic [1:0] c3_hist, en_hist;  // last two samples
    logic c3_prev;
    err0 = errors;
    n_en = 0;
    last_en = -1;
    c3_hist = '0;
    en_hist = '0;
    c3_prev = 1'b0;
    for (i = 0; i < 400; i++) begin
      @(negedge clk_28);
      if (phases.clk7_en) begin
        if (last_en >= 0 && i - last_en != 4) wrong_value("clk7_en spacing not 4");
        last_en = i;
        n_en++;
      end
      if (i >= 2 && phases.clk7n_en != en_hist[1]) wrong_value("clk7n_en not 2 after clk7_en");
      if (i >= 2 && phases.c3 == c3_hist[1]) wrong_value("c3 period not 4");  // half period 2
      if (i >= 1 && phases.c1 != ~c3_prev) wrong_value("c1 not inverted c3 delayed");
      c3_hist = {c3_hist[0], phases.c3};
      en_hist = {en_hist[0], phases.clk7_en};
      c3_prev = phases.c3;
    end
    if (n_en != 100) wrong_value($sformatf("clk7_en count %0d, expected 100", n_en));
    close_test("clock phases", err0);
  endtask

  // E-clock phase order, cck and eclk_en spacing
  task automatic scan_eclk_phases();
    int err0, i, idx, prev_idx, held, cck_held, last_e;
    int n_steps, n_cck, n_e;
    logic cck_prev;
    err0 = errors;
    prev_idx = -1;
    held = 0;
    cck_held = -1;
    last_e = -1;
    n_steps = 0;
    n_cck = 0;
    n_e = 0;
    cck_prev = phases.cck;
    for (i = 0; i < 240; i++) begin
      @(negedge clk_28);
      idx = -1;
      for (int k = 0; k < 10; k++) begin
        if (phases.eclk[k]) idx = k;
      end
      if (idx != prev_idx) begin
        if (prev_idx >= 0 && idx != (prev_idx + 1) % 10) wrong_value("eclk phase out of order");
        if (held > 0 && held != 4) wrong_value("eclk phase not held 4 cycles");
        if (prev_idx >= 0) n_steps++;
        held = (prev_idx >= 0) ? 1 : 0;
        prev_idx = idx;
      end else if (held > 0) held++;
      if (phases.cck != cck_prev) begin
        if (cck_held > 0 && cck_held != 4) wrong_value("cck not toggling every 4 cycles");
        cck_held = 1;
        cck_prev = phases.cck;
        n_cck++;
      end else if (cck_held > 0) cck_held++;
      if (dut0.eclk_en) begin
        if (last_e >= 0 && i - last_e != 40) wrong_value("eclk_en spacing not 40");
        last_e = i;
        n_e++;
      end
    end
    // 240 samples span 59 or 60 steps of 4 cycles
    if (n_steps < 59)
      wrong_value($sformatf("%0d eclk phase steps, expected at least 59", n_steps));
    if (n_cck < 59)
      wrong_value($sformatf("%0d cck toggles, expected at least 59", n_cck));
    if (n_e != 6) wrong_value($sformatf("%0d eclk_en strobes, expected 6", n_e));
    close_test("eclk phases", err0);
  endtask

  function automatic sync_t sync_expect(input beam_pos_t b);
    sync_t s;
    s.hsync = (b.hpos >= `AT_HSYNC_START) && (b.hpos < `AT_HSYNC_END);
    s.vsync = (b.vpos >= `AT_VSYNC_START) && (b.vpos < `AT_VSYNC_END);
    s.blank = ((b.hpos >= `AT_HBLANK_START) && (b.hpos < `AT_HBLANK_END)) ||
              (b.vpos < `AT_VBLANK_END);
    return s;
  endfunction

  // one full frame of beam stepping and sync decode
  task automatic walk_frame();
    int err0, i, since_h, v_wraps;
    beam_pos_t prev;
    err0 = errors;
    since_h = -1;
    v_wraps = 0;
    @(negedge clk_28);
    prev = beam;
    for (i = 0; i < FRAME_CYC; i++) begin
      @(negedge clk_28);
      if (sync != sync_expect(prev))
        wrong_value($sformatf("sync for h%0d v%0d", prev.hpos, prev.vpos));
      if (since_h >= 0) since_h++;
      if (beam.hpos != prev.hpos) begin
        if (beam.hpos != (prev.hpos + 1) % `AT_HTOTAL) wrong_value("hpos step wrong");
        if (since_h > 0 && since_h != 8) wrong_value("hpos not advancing every 8 cycles");
        since_h = 0;
      end
      if (beam.vpos != prev.vpos) begin
        if (beam.hpos != 0) wrong_value("vpos moved without hpos wrap");
        if (beam.vpos != (prev.vpos + 1) % `AT_VTOTAL) wrong_value("vpos step wrong");
        if (beam.vpos == 0) v_wraps++;
      end else if (beam.hpos == 0 && prev.hpos != 0) wrong_value("hpos wrap without vpos step");
      prev = beam;
    end
    if (v_wraps != 1) wrong_value($sformatf("%0d frame wraps in one frame time", v_wraps));
    close_test("beam and sync frame", err0);
  endtask

  // one table row: load, start, watch irq spacing, then stop
  task automatic run_timer_case(input int r);
    int err0, i, n, last_irq, gap, hold;
    logic [15:0] held_count;
    err0 = errors;
    n = 0;
    last_irq = -1;
    gap = (tc_reload[r] + 1) * 40;
    @(posedge clk_28);
    timer_ctrl <= '{load: 1'b1, start: 1'b0, oneshot: tc_oneshot[r], reload: 16'(tc_reload[r])};
    @(posedge clk_28);
    timer_ctrl.load <= 1'b0;
    timer_ctrl.start <= 1'b1;
    for (i = 0; i < tc_window[r] && n < tc_pulses[r]; i++) begin
      @(negedge clk_28);
      if (timer_irq) begin
        if (last_irq >= 0 && i - last_irq != gap)
          wrong_value($sformatf("irq gap %0d, expected %0d", i - last_irq, gap));
        last_irq = i;
        n++;
      end
    end
    if (n != tc_pulses[r]) wrong_value($sformatf("%0d irqs, expected %0d", n, tc_pulses[r]));
    if (tc_oneshot[r]) begin
      @(negedge clk_28);
      held_count = timer_count;
      for (hold = 0; hold < 2 * gap + 80; hold++) begin
        @(negedge clk_28);
        if (timer_irq) wrong_value("one-shot timer pulsed again");
        if (timer_count != held_count) wrong_value("one-shot count moved after underflow");
      end
    end
    @(posedge clk_28);
    timer_ctrl.start <= 1'b0;
    repeat (2) @(posedge clk_28);
    close_test($sformatf("timer reload %0d %s", tc_reload[r],
      tc_oneshot[r] ? "one-shot" : "continuous"), err0);
  endtask

  // load while running restarts the interval
  task automatic reload_while_running();
    int err0, i;
    err0 = errors;
    @(posedge clk_28);
    timer_ctrl <= '{load: 1'b1, start: 1'b0, oneshot: 1'b0, reload: 16'd20};
    @(posedge clk_28);
    timer_ctrl.load <= 1'b0;
    timer_ctrl.start <= 1'b1;
    for (i = 0; i < 21 * 40 + 80 && !timer_irq; i++) @(negedge clk_28);
    if (!timer_irq) missing_event("no irq before reload");
    repeat (100) @(posedge clk_28);
    timer_ctrl.load <= 1'b1;
    timer_ctrl.reload <= 16'd2;
    @(posedge clk_28);
    timer_ctrl.load <= 1'b0;
    for (i = 0; i <= 3 * 40 + 2 && !timer_irq; i++) @(negedge clk_28);
    if (!timer_irq) missing_event("irq not within new reload interval after load");
    @(posedge clk_28);
    timer_ctrl.start <= 1'b0;
    close_test("reload while running", err0);
  endtask

  initial begin
    locked = 1'b0;
    timer_ctrl = '0;
    tc_reload = '{0, 3, 17, $random(seed) & 32'h3f, 3};
    tc_oneshot = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    tc_pulses = '{3, 3, 3, 3, 1};
    timeout_cycles = 2 * FRAME_CYC + 4000 + 30 * 40;
    for (int r = 0; r < NCASE; r++) begin
      tc_window[r] = (tc_reload[r] + 2) * 40 * (tc_pulses[r] + 1);
      timeout_cycles += tc_window[r] + 3 * (tc_reload[r] + 2) * 40;
    end
    repeat (3) @(posedge clk_28);
    locked <= 1'b1;
    run_clock_phases();
    scan_eclk_phases();
    walk_frame();
    for (int r = 0; r < NCASE; r++) run_timer_case(r);
    reload_while_running();
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/amiga_timing_props.sv */
// timing properties
// strobe spacing, enable nesting, irq width and E-clock phase encoding
// bound into clock_enables and eclk_timer

`default_nettype none

module amiga_timing_props (
  input logic       clk_28,
  input logic       locked,
  input logic       clk7_en,
  input logic       eclk_en,
  input logic [9:0] eclk,
  input logic       irq
);
  timeunit 1ns;
  timeprecision 100ps;

  a_clk7_gap: assert property (@(posedge clk_28) disable iff (!locked)
    clk7_en |=> !clk7_en) else $error("clk7_en high on two cycles in a row");

  a_eclk_nest: assert property (@(posedge clk_28) disable iff (!locked)
    eclk_en |-> clk7_en) else $error("eclk_en without clk7_en");

  a_irq_width: assert property (@(posedge clk_28) disable iff (!locked)
    irq |=> !irq) else $error("timer irq longer than one cycle");

  a_eclk_onehot: assert property (@(posedge clk_28) disable iff (!locked)
    $onehot(eclk)) else $error("eclk phase lines not one-hot");

endmodule

// clock side gets no irq, timer side gets no phases
bind clock_enables amiga_timing_props props_clk (.clk_28(clk_28), .locked(locked),
  .clk7_en(phases.clk7_en), .eclk_en(eclk_en), .eclk(phases.eclk), .irq(1'b0));
bind eclk_timer amiga_timing_props props_tmr (.clk_28(clk_28), .locked(locked),
  .clk7_en(1'b0), .eclk_en(1'b0), .eclk(10'd1), .irq(irq));

`default_nettype wire

/* logic/amiga_timing_top.sv */
// amiga timing top
// timing core of the chipset
// clock enables feed the beam counter, the sync decode and the E-clock timer

`default_nettype none

module amiga_timing_top
  import amiga_timing_pkg::*;
(
  input  logic        clk_28,       // 28 MHz master clock
  input  logic        locked,       // held in reset while low
  input  timer_ctrl_t timer_ctrl,   // interval timer control
  output clk_phase_t  phases,       // amiga clock phases
  output beam_pos_t   beam,         // beam position
  output sync_t       sync,         // hsync, vsync, blank
  output logic [15:0] timer_count,  // interval timer count
  output logic        timer_irq     // timer underflow
);

  logic cck_en;   // colour clock strobe
  logic eclk_en;  // E-clock strobe

  clock_enables clock_enables0 (
    .clk_28  (clk_28),
    .locked  (locked),
    .phases  (phases),
    .cck_en  (cck_en),
    .eclk_en (eclk_en)
  );

  beam_counter beam_counter0 (
    .clk_28 (clk_28),
    .locked (locked),
    .cck_en (cck_en),
    .beam   (beam)
  );

  eclk_timer eclk_timer0 (
    .clk_28  (clk_28),
    .locked  (locked),
    .eclk_en (eclk_en),
    .ctrl    (timer_ctrl),
    .count   (timer_count),
    .irq     (timer_irq)
  );

  video_sync video_sync0 (
    .clk_28 (clk_28),
    .locked (locked),
    .beam   (beam),
    .sync   (sync)
  );

endmodule

`default_nettype wire

/* logic/video_sync.sv */
// video sync
// decodes hsync, vsync and blank from the beam position
// flags are registered so they trail the beam by one cycle

`include "amiga_timing_params.svh"
`default_nettype none

module video_sync
  import amiga_timing_pkg::*;
(
  input  logic      clk_28,   // 28 MHz master clock
  input  logic      locked,   // held in reset while low
  input  beam_pos_t beam,     // beam position
  output sync_t     sync      // registered sync flags
);

  logic hsync_win;
  logic vsync_win;
  logic hblank_win;
  logic vblank_win;

  // horizontal windows
  assign hsync_win  = (beam.hpos >= 9'(`AT_HSYNC_START)) &&
                      (beam.hpos <  9'(`AT_HSYNC_END));
  assign hblank_win = (beam.hpos >= 9'(`AT_HBLANK_START)) &&
                      (beam.hpos <  9'(`AT_HBLANK_END));

  // vertical windows
  assign vsync_win  = (beam.vpos >= 9'(`AT_VSYNC_START)) &&
                      (beam.vpos <  9'(`AT_VSYNC_END));
  assign vblank_win = (beam.vpos <  9'(`AT_VBLANK_END));  // top of frame

  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      sync <= '0;
    end else begin
      sync.hsync <= hsync_win;
      sync.vsync <= vsync_win;
      sync.blank <= hblank_win || vblank_win;  // either blanking region
    end
  end

endmodule

`default_nettype wire

/* logic/eclk_timer.sv */
// eclk timer
// CIA-style 16-bit interval timer clocked by E-clock ticks
// reloads on underflow and pulses irq for one cycle
// one-shot mode halts after the first underflow

`default_nettype none

module eclk_timer
  import amiga_timing_pkg::*;
(
  input  logic        clk_28,   // 28 MHz master clock
  input  logic        locked,   // held in reset while low
  input  logic        eclk_en,  // E-clock tick
  input  timer_ctrl_t ctrl,     // load, start, mode and reload value
  output logic [15:0] count,    // current count
  output logic        irq       // underflow pulse
);

  timer_state_e state;
  logic         tick;       // counting edge
  logic         underflow;  // tick at zero count

  assign tick      = (state == TMR_RUN) && ctrl.start && eclk_en;
  assign underflow = tick && (count == 16'd0);

  // run control
  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      state <= TMR_IDLE;
    end else begin
      case (state)
        TMR_IDLE: begin
          if (ctrl.start) begin
            state <= TMR_RUN;
          end
        end
        TMR_RUN: begin
          if (!ctrl.start) begin
            state <= TMR_IDLE;  // stop on start low
          end else if (underflow && ctrl.oneshot) begin
            state <= TMR_DONE;
          end
        end
        TMR_DONE: begin
          if (!ctrl.start) begin
            state <= TMR_IDLE;
          end
        end
        default: begin
          state <= TMR_IDLE;
        end
      endcase
    end
  end

  // counter
  // load wins over the tick in the same cycle
  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      count <= 16'd0;
    end else if (ctrl.load) begin
      count <= ctrl.reload;        // load in any state
    end else if (underflow) begin
      count <= ctrl.reload;        // auto reload
    end else if (tick) begin
      count <= count - 16'd1;
    end
  end

  // interrupt
  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      irq <= 1'b0;
    end else begin
      irq <= underflow;  // single cycle
    end
  end

endmodule

`default_nettype wire

/* logic/beam_counter.sv */
// beam counter
// counts colour clocks across a PAL line and lines across a frame
// horizontal wrap is the only thing that moves vpos

`include "amiga_timing_params.svh"
`default_nettype none

module beam_counter
  import amiga_timing_pkg::*;
(
  input  logic      clk_28,   // 28 MHz master clock
  input  logic      locked,   // held in reset while low
  input  logic      cck_en,   // colour clock strobe
  output beam_pos_t beam      // current beam position
);

  beam_pos_t beam_r;
  logic      h_wrap;   // last colour clock of the line
  logic      v_wrap;   // last line of the frame

  assign h_wrap = (beam_r.hpos == 9'(`AT_HTOTAL - 1));
  assign v_wrap = (beam_r.vpos == 9'(`AT_VTOTAL - 1));

  // horizontal position
  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      beam_r.hpos <= 9'd0;
    end else if (cck_en) begin
      if (h_wrap) begin
        beam_r.hpos <= 9'd0;
      end else begin
        beam_r.hpos <= beam_r.hpos + 9'd1;
      end
    end
  end

  // vertical position
  // steps once per line on the hpos wrap
  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      beam_r.vpos <= 9'd0;
    end else if (cck_en && h_wrap) begin
      if (v_wrap) begin
        beam_r.vpos <= 9'd0;  // new frame
      end else begin
        beam_r.vpos <= beam_r.vpos + 9'd1;
      end
    end
  end

  assign beam = beam_r;

endmodule

`default_nettype wire

/* logic/clock_enables.sv */
// clock enables
// divides clk_28 into the 7 MHz enables, the c1/c3 quadrature,
// the colour clock and the ten E-clock phases
// also registers the cck_en and eclk_en strobes for the core

`include "amiga_timing_params.svh"
`default_nettype none

module clock_enables
  import amiga_timing_pkg::*;
(
  input  logic       clk_28,   // 28 MHz master clock
  input  logic       locked,   // held in reset while low
  output clk_phase_t phases,   // phase bundle
  output logic       cck_en,   // one cycle per colour clock
  output logic       eclk_en   // one cycle per E-clock
);

  logic [1:0] clk7_cnt;    // 7 MHz phase
  logic       clk7_en_r;
  logic       clk7n_en_r;
  logic       clk_7;       // 7 MHz level
  logic       c3_r;
  logic       c1_r;
  logic [3:0] e_cnt;       // E-clock phase 0..9
  logic [3:0] e_cnt_nxt;
  logic       cck_r;
  logic       cck_en_r;
  logic       eclk_en_r;
  logic [9:0] eclk;        // one-hot decode of e_cnt

  // 7 MHz divider, starts at 2 out of reset
  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      clk7_cnt   <= 2'd2;
      clk7_en_r  <= 1'b0;
      clk7n_en_r <= 1'b0;
    end else begin
      clk7_cnt   <= clk7_cnt + 2'd1;
      clk7_en_r  <= (clk7_cnt == 2'd0);
      clk7n_en_r <= (clk7_cnt == 2'd2);  // two cycles after clk7_en
    end
  end

  assign clk_7 = clk7_cnt[1];

  // c3 trails clk_7 by one cycle
  // c1 is inverted c3 one cycle later
  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      c3_r <= 1'b0;
      c1_r <= 1'b0;
    end else begin
      c3_r <= clk_7;
      c1_r <= ~c3_r;
    end
  end

  // E-clock phase steps once per 7 MHz period
  always_comb begin
    e_cnt_nxt = e_cnt;
    if (clk7_cnt == 2'd1) begin
      if (e_cnt == 4'(`AT_ECLK_PHASES - 1)) begin
        e_cnt_nxt = 4'd0;  // wrap after phase 9
      end else begin
        e_cnt_nxt = e_cnt + 4'd1;
      end
    end
  end

  // E-clock phase, colour clock level and the two strobes
  always_ff @(posedge clk_28 or negedge locked) begin
    if (!locked) begin
      e_cnt     <= 4'd0;
      cck_r     <= 1'b0;
      cck_en_r  <= 1'b0;
      eclk_en_r <= 1'b0;
    end else begin
      e_cnt     <= e_cnt_nxt;
      cck_r     <= ~e_cnt_nxt[0];
      cck_en_r  <= (clk7_cnt == 2'd0) && !e_cnt[0];    // lines up with clk7_en
      eclk_en_r <= (clk7_cnt == 2'd0) && (e_cnt == 4'd0);
    end
  end

  // phase decode
  always_comb begin
    for (int i = 0; i < `AT_ECLK_PHASES; i++) begin
      eclk[i] = (e_cnt == 4'(i));
    end
  end

  assign phases = '{
    clk7_en:  clk7_en_r,
    clk7n_en: clk7n_en_r,
    c1:       c1_r,
    c3:       c3_r,
    cck:      cck_r,
    eclk:     eclk
  };

  assign cck_en  = cck_en_r;
  assign eclk_en = eclk_en_r;

endmodule

`default_nettype wire

/* logic/amiga_timing_pkg.sv */
// amiga timing types
// bundles shared between the clock, beam, timer and sync blocks

`default_nettype none

package amiga_timing_pkg;

  // clock phase outputs of clock_enables
  typedef struct packed {
    logic       clk7_en;   // 7 MHz enable, one in four
    logic       clk7n_en;  // 7 MHz negedge enable
    logic       c1;        // quadrature level
    logic       c3;        // c1 shifted 90 deg
    logic       cck;       // colour clock level
    logic [9:0] eclk;      // one-hot E-clock phase
  } clk_phase_t;

  // beam position in colour clocks and lines
  typedef struct packed {
    logic [8:0] hpos;
    logic [8:0] vpos;
  } beam_pos_t;

  // interval timer control
  typedef struct packed {
    logic        load;     // strobe, copies reload
    logic        start;    // level, run while high
    logic        oneshot;  // level, halt after first underflow
    logic [15:0] reload;   // reload value
  } timer_ctrl_t;

  // video sync flags, all active high
  typedef struct packed {
    logic hsync;
    logic vsync;
    logic blank;
  } sync_t;

  // interval timer states
  typedef enum logic [1:0] {
    TMR_IDLE,  // stopped
    TMR_RUN,   // counting eclk ticks
    TMR_DONE   // one-shot expired, wait for start low
  } timer_state_e;

endpackage

`default_nettype wire

/* logic/amiga_timing_params.svh */
// amiga timing geometry
// PAL frame size, sync and blank windows, E-clock division
// windows run from start inclusive to end exclusive

`ifndef AMIGA_TIMING_PARAMS_SVH
`define AMIGA_TIMING_PARAMS_SVH

// frame size in colour clocks and lines
`define AT_HTOTAL        227
`define AT_VTOTAL        312

// horizontal sync window in hpos
`define AT_HSYNC_START   18
`define AT_HSYNC_END     35

// horizontal blank window in hpos
`define AT_HBLANK_START  15
`define AT_HBLANK_END    55

// vertical sync window in vpos
`define AT_VSYNC_START   2
`define AT_VSYNC_END     5

// vblank from line 0 up to here
`define AT_VBLANK_END    25

// 7 MHz periods per E-clock
`define AT_ECLK_PHASES   10

`endif
